// ==== regGpr_settings.svh ====
`ifndef REGGPR_SETTINGS_SVH
`define REGGPR_SETTINGS_SVH

// Number of general registers held in the banks
`define GPR_COUNT	32

// Special registers, stored beside the banks
`define GR_DLR		6'h20	// Low data register
`define GR_DHR		6'h21	// High data register
`define GR_SP		6'h22	// Stack pointer

// Control values, read only from the register file side
`define GR_PC		6'h23	// Program counter
`define GR_GBR		6'h24	// Global base register
`define GR_LR		6'h25	// Link register

// Decode-supplied sources
`define GR_IMM		6'h3E	// Lane immediate, sign extended on read

// Zero on read, and "no destination" as a write target
`define GR_ZZR		6'h3F

`endif

// ==== regGprPkg.sv ====
package regGprPkg;

	// Register ID as seen by decode and the EX stages
	typedef logic [5:0]		regIdT;

	typedef logic [63:0]	regValT;	// GPR or special register value

	typedef logic [4:0]		gprIndexT;	// Bank index, low bits of a GPR ID

	// PC, GBR and LR are 48-bit addresses
	typedef logic [47:0]	addrValT;

	typedef logic [32:0]	immValT;	// Bit 32 carries the sign

endpackage

// ==== gprBankLvt.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module gprBankLvt (
	input logic					clock,
	input logic					reset,
	input logic					hold,
	input logic					wbFlush,
	input regGprPkg::regIdT		wbIdA,
	input regGprPkg::regIdT		wbIdB,
	input regGprPkg::regValT	wbValA,
	input regGprPkg::regValT	wbValB,
	input regGprPkg::gprIndexT	rdIndex0,
	input regGprPkg::gprIndexT	rdIndex1,
	input regGprPkg::gprIndexT	rdIndex2,
	input regGprPkg::gprIndexT	rdIndex3,
	output regGprPkg::regValT	rdVal0,
	output regGprPkg::regValT	rdVal1,
	output regGprPkg::regValT	rdVal2,
	output regGprPkg::regValT	rdVal3
);

	regGprPkg::regValT	bankA [`GPR_COUNT];	// Written by lane A only
	regGprPkg::regValT	bankB [`GPR_COUNT];	// Written by lane B only
	logic [`GPR_COUNT-1:0]	live;	// Set means bank B holds the current copy

	logic	wrEnA;
	logic	wrEnB;
	regGprPkg::gprIndexT	wrIdxA;
	regGprPkg::gprIndexT	wrIdxB;

	// Special IDs and ZZR fall outside the bank range and are dropped here
	assign wrEnA = !hold && !wbFlush && (wbIdA < `GPR_COUNT);
	assign wrEnB = !hold && !wbFlush && (wbIdB < `GPR_COUNT);
	assign wrIdxA = wbIdA[4:0];
	assign wrIdxB = wbIdB[4:0];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `GPR_COUNT; i++)
			begin
				bankA[i] <= '0;
				bankB[i] <= '0;
			end
			live <= '0;
		end
		else
		begin
			if (wrEnA)
			begin
				bankA[wrIdxA] <= wbValA;
				live[wrIdxA] <= 1'b0;
			end
			if (wrEnB)
			begin
				bankB[wrIdxB] <= wbValB;
				live[wrIdxB] <= 1'b1;	// Comes last so lane B wins a collision
			end
		end
	end

	function automatic regGprPkg::regValT readBank(input regGprPkg::gprIndexT idx);
		readBank = live[idx] ? bankB[idx] : bankA[idx];
	endfunction

	always_comb
	begin
		rdVal0 = readBank(rdIndex0);
		rdVal1 = readBank(rdIndex1);
		rdVal2 = readBank(rdIndex2);
		rdVal3 = readBank(rdIndex3);
	end

endmodule

// ==== sprReg.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module sprReg #(
	parameter regGprPkg::regIdT regId = `GR_DLR	// ID this register answers to
) (
	input logic					clock,
	input logic					reset,
	input logic					hold,
	input logic					wbFlush,
	input regGprPkg::regIdT		wbIdA,
	input regGprPkg::regIdT		wbIdB,
	input regGprPkg::regValT	wbValA,
	input regGprPkg::regValT	wbValB,
	input regGprPkg::regValT	inVal,
	output regGprPkg::regValT	outVal
);

	logic	hitA;
	logic	hitB;

	assign hitA = !wbFlush && (wbIdA == regId);
	assign hitB = !wbFlush && (wbIdB == regId);

	always_ff @(posedge clock)
	begin
		if (reset)
			outVal <= '0;
		else if (!hold)
		begin
			if (hitA)
				outVal <= wbValA;	// Lane A has priority here
			else if (hitB)
				outVal <= wbValB;
			else
				outVal <= inVal;	// Track the external copy
		end
	end

endmodule

// ==== gprReadPort.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module gprReadPort (
	input regGprPkg::regIdT		srcId,
	input regGprPkg::regValT	bankVal,
	input regGprPkg::regValT	dlrVal,
	input regGprPkg::regValT	dhrVal,
	input regGprPkg::regValT	spVal,
	input regGprPkg::addrValT	pcVal,
	input regGprPkg::addrValT	gbrVal,
	input regGprPkg::addrValT	lrVal,
	input regGprPkg::immValT	immVal,
	input regGprPkg::regIdT		ex1IdA,
	input regGprPkg::regValT	ex1ValA,
	input regGprPkg::regIdT		ex1IdB,
	input regGprPkg::regValT	ex1ValB,
	input regGprPkg::regIdT		ex2IdA,
	input regGprPkg::regValT	ex2ValA,
	input regGprPkg::regIdT		ex2IdB,
	input regGprPkg::regValT	ex2ValB,
	input regGprPkg::regIdT		ex3IdA,
	input regGprPkg::regValT	ex3ValA,
	input regGprPkg::regIdT		ex3IdB,
	input regGprPkg::regValT	ex3ValB,
	output regGprPkg::regValT	srcVal
);

	regGprPkg::regValT	baseVal;
	logic				noForward;

	// Base value from the ID alone
	always_comb
	begin
		if (srcId < `GPR_COUNT)
			baseVal = bankVal;
		else
		begin
			case (srcId)
				`GR_DLR:	baseVal = dlrVal;
				`GR_DHR:	baseVal = dhrVal;
				`GR_SP:		baseVal = spVal;
				`GR_PC:		baseVal = {16'h0000, pcVal};
				`GR_GBR:	baseVal = {16'h0000, gbrVal};
				`GR_LR:		baseVal = {16'h0000, lrVal};
				`GR_IMM:	baseVal = {{31{immVal[32]}}, immVal};
				default:	baseVal = '0;	// ZZR and unassigned IDs
			endcase
		end
	end

	// Immediates and ZZR are never stage results
	assign noForward = (srcId == `GR_IMM) || (srcId == `GR_ZZR);

	// Oldest first, so the newest stage and lane A end up on top
	always_comb
	begin
		srcVal = baseVal;
		if (!noForward)
		begin
			if (srcId == ex3IdB)
				srcVal = ex3ValB;
			if (srcId == ex3IdA)
				srcVal = ex3ValA;
			if (srcId == ex2IdB)
				srcVal = ex2ValB;
			if (srcId == ex2IdA)
				srcVal = ex2ValA;
			if (srcId == ex1IdB)
				srcVal = ex1ValB;
			if (srcId == ex1IdA)
				srcVal = ex1ValA;
		end
	end

endmodule

// ==== regGpr4R2W.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module regGpr4R2W (
	input logic					clock,
	input logic					reset,
	input logic					hold,
	input regGprPkg::regIdT		idRs,	// Lane A sources
	input regGprPkg::regIdT		idRt,
	input regGprPkg::regIdT		idRu,	// Lane B sources
	input regGprPkg::regIdT		idRv,
	input regGprPkg::regIdT		ex1IdA,
	input regGprPkg::regValT	ex1ValA,
	input regGprPkg::regIdT		ex1IdB,
	input regGprPkg::regValT	ex1ValB,
	input regGprPkg::regIdT		ex2IdA,
	input regGprPkg::regValT	ex2ValA,
	input regGprPkg::regIdT		ex2IdB,
	input regGprPkg::regValT	ex2ValB,
	input regGprPkg::regIdT		ex3IdA,	// EX3 doubles as writeback
	input regGprPkg::regValT	ex3ValA,
	input regGprPkg::regIdT		ex3IdB,
	input regGprPkg::regValT	ex3ValB,
	input logic					ex3Flush,
	input regGprPkg::addrValT	valPc,
	input regGprPkg::addrValT	valGbr,
	input regGprPkg::addrValT	valLr,
	input regGprPkg::immValT	immA,
	input regGprPkg::immValT	immB,
	input regGprPkg::regValT	inDlr,
	input regGprPkg::regValT	inDhr,
	input regGprPkg::regValT	inSp,
	output regGprPkg::regValT	valRs,
	output regGprPkg::regValT	valRt,
	output regGprPkg::regValT	valRu,
	output regGprPkg::regValT	valRv,
	output regGprPkg::regValT	outDlr,
	output regGprPkg::regValT	outDhr,
	output regGprPkg::regValT	outSp
);

	regGprPkg::regValT	bankRs;
	regGprPkg::regValT	bankRt;
	regGprPkg::regValT	bankRu;
	regGprPkg::regValT	bankRv;

	gprBankLvt banks (
		.clock(clock), .reset(reset), .hold(hold), .wbFlush(ex3Flush),
		.wbIdA(ex3IdA), .wbIdB(ex3IdB), .wbValA(ex3ValA), .wbValB(ex3ValB),
		.rdIndex0(idRs[4:0]), .rdIndex1(idRt[4:0]),
		.rdIndex2(idRu[4:0]), .rdIndex3(idRv[4:0]),
		.rdVal0(bankRs), .rdVal1(bankRt), .rdVal2(bankRu), .rdVal3(bankRv)
	);

	sprReg #(.regId(`GR_DLR)) dlrReg (
		.clock(clock), .reset(reset), .hold(hold), .wbFlush(ex3Flush),
		.wbIdA(ex3IdA), .wbIdB(ex3IdB), .wbValA(ex3ValA), .wbValB(ex3ValB),
		.inVal(inDlr), .outVal(outDlr)
	);

	sprReg #(.regId(`GR_DHR)) dhrReg (
		.clock(clock), .reset(reset), .hold(hold), .wbFlush(ex3Flush),
		.wbIdA(ex3IdA), .wbIdB(ex3IdB), .wbValA(ex3ValA), .wbValB(ex3ValB),
		.inVal(inDhr), .outVal(outDhr)
	);

	sprReg #(.regId(`GR_SP)) spReg (
		.clock(clock), .reset(reset), .hold(hold), .wbFlush(ex3Flush),
		.wbIdA(ex3IdA), .wbIdB(ex3IdB), .wbValA(ex3ValA), .wbValB(ex3ValB),
		.inVal(inSp), .outVal(outSp)
	);

	// Lane A ports use immA
	gprReadPort portRs (
		.srcId(idRs), .bankVal(bankRs), .dlrVal(outDlr), .dhrVal(outDhr), .spVal(outSp),
		.pcVal(valPc), .gbrVal(valGbr), .lrVal(valLr), .immVal(immA),
		.ex1IdA(ex1IdA), .ex1ValA(ex1ValA), .ex1IdB(ex1IdB), .ex1ValB(ex1ValB),
		.ex2IdA(ex2IdA), .ex2ValA(ex2ValA), .ex2IdB(ex2IdB), .ex2ValB(ex2ValB),
		.ex3IdA(ex3IdA), .ex3ValA(ex3ValA), .ex3IdB(ex3IdB), .ex3ValB(ex3ValB),
		.srcVal(valRs)
	);

	gprReadPort portRt (
		.srcId(idRt), .bankVal(bankRt), .dlrVal(outDlr), .dhrVal(outDhr), .spVal(outSp),
		.pcVal(valPc), .gbrVal(valGbr), .lrVal(valLr), .immVal(immA),
		.ex1IdA(ex1IdA), .ex1ValA(ex1ValA), .ex1IdB(ex1IdB), .ex1ValB(ex1ValB),
		.ex2IdA(ex2IdA), .ex2ValA(ex2ValA), .ex2IdB(ex2IdB), .ex2ValB(ex2ValB),
		.ex3IdA(ex3IdA), .ex3ValA(ex3ValA), .ex3IdB(ex3IdB), .ex3ValB(ex3ValB),
		.srcVal(valRt)
	);

	// Lane B ports use immB
	gprReadPort portRu (
		.srcId(idRu), .bankVal(bankRu), .dlrVal(outDlr), .dhrVal(outDhr), .spVal(outSp),
		.pcVal(valPc), .gbrVal(valGbr), .lrVal(valLr), .immVal(immB),
		.ex1IdA(ex1IdA), .ex1ValA(ex1ValA), .ex1IdB(ex1IdB), .ex1ValB(ex1ValB),
		.ex2IdA(ex2IdA), .ex2ValA(ex2ValA), .ex2IdB(ex2IdB), .ex2ValB(ex2ValB),
		.ex3IdA(ex3IdA), .ex3ValA(ex3ValA), .ex3IdB(ex3IdB), .ex3ValB(ex3ValB),
		.srcVal(valRu)
	);

	gprReadPort portRv (
		.srcId(idRv), .bankVal(bankRv), .dlrVal(outDlr), .dhrVal(outDhr), .spVal(outSp),
		.pcVal(valPc), .gbrVal(valGbr), .lrVal(valLr), .immVal(immB),
		.ex1IdA(ex1IdA), .ex1ValA(ex1ValA), .ex1IdB(ex1IdB), .ex1ValB(ex1ValB),
		.ex2IdA(ex2IdA), .ex2ValA(ex2ValA), .ex2IdB(ex2IdB), .ex2ValB(ex2ValB),
		.ex3IdA(ex3IdA), .ex3ValA(ex3ValA), .ex3IdB(ex3IdB), .ex3ValB(ex3ValB),
		.srcVal(valRv)
	);

endmodule

// ==== regGpr_assertions.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module regGprAssertions (
	input logic					clock,
	input logic					reset,
	input logic					hold,
	input regGprPkg::regIdT		idRs,
	input regGprPkg::regIdT		idRv,
	input regGprPkg::immValT	immA,
	input regGprPkg::regValT	valRs,
	input regGprPkg::regValT	valRv,
	input regGprPkg::regValT	outDlr,
	input regGprPkg::regValT	outDhr,
	input regGprPkg::regValT	outSp
);

	// Zero register ignores any matching stage result
	zzrRs: assert property (@(posedge clock) disable iff (reset)
		(idRs == `GR_ZZR) |-> (valRs == '0))
		else $error("ZZR read on Rs is not zero");

	zzrRv: assert property (@(posedge clock) disable iff (reset)
		(idRv == `GR_ZZR) |-> (valRv == '0))
		else $error("ZZR read on Rv is not zero");

	immRs: assert property (@(posedge clock) disable iff (reset)
		(idRs == `GR_IMM) |-> (valRs == 64'(signed'(immA))))	// Lane A immediate
		else $error("Immediate read on Rs is not immA sign extended");

	holdSp: assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable(outSp))
		else $error("SP changed across a hold cycle");

	resetSpecials: assert property (@(posedge clock)
		reset |=> (outDlr == '0 && outDhr == '0 && outSp == '0))
		else $error("Special registers not cleared by reset");

endmodule

bind regGpr4R2W regGprAssertions checks (
	.clock(clock), .reset(reset), .hold(hold), .idRs(idRs), .idRv(idRv), .immA(immA),
	.valRs(valRs), .valRv(valRv), .outDlr(outDlr), .outDhr(outDhr), .outSp(outSp)
);

// ==== tbRegGpr.sv ====
`timescale 1ns/10ps
`include "regGpr_settings.svh"

module tbRegGpr;

	localparam int RANDOM_CYCLES = 2000;
	localparam int CYCLE_LIMIT = RANDOM_CYCLES + 100;	// Reset and directed reads fit well inside

	logic	clock;
	logic	reset;
	logic	hold;
	logic	ex3Flush;
	regGprPkg::regIdT	idRs, idRt, idRu, idRv;
	regGprPkg::regIdT	fwdId [6];	// EX1 A, EX1 B, EX2 A, EX2 B, EX3 A, EX3 B
	regGprPkg::regValT	fwdVal [6];
	regGprPkg::addrValT	valPc, valGbr, valLr;
	regGprPkg::immValT	immA, immB;
	regGprPkg::regValT	inDlr, inDhr, inSp;
	regGprPkg::regValT	valRs, valRt, valRu, valRv, outDlr, outDhr, outSp;

	// Reference state
	regGprPkg::regValT	gprModel [`GPR_COUNT];
	regGprPkg::regValT	dlrModel, dhrModel, spModel;

	regGprPkg::regIdT	destSpecials [5] = '{`GR_DLR, `GR_DHR, `GR_SP, `GR_PC, `GR_IMM};
	regGprPkg::regIdT	srcSpecials [10] = '{`GR_DLR, `GR_DHR, `GR_SP, `GR_PC, `GR_GBR,
		`GR_LR, `GR_IMM, `GR_ZZR, 6'h26, 6'h3D};	// Last two are unassigned IDs

	integer	seed;
	int		cycleCount = 0;

	regGpr4R2W UUT (
		.clock(clock), .reset(reset), .hold(hold),
		.idRs(idRs), .idRt(idRt), .idRu(idRu), .idRv(idRv),
		.ex1IdA(fwdId[0]), .ex1ValA(fwdVal[0]), .ex1IdB(fwdId[1]), .ex1ValB(fwdVal[1]),
		.ex2IdA(fwdId[2]), .ex2ValA(fwdVal[2]), .ex2IdB(fwdId[3]), .ex2ValB(fwdVal[3]),
		.ex3IdA(fwdId[4]), .ex3ValA(fwdVal[4]), .ex3IdB(fwdId[5]), .ex3ValB(fwdVal[5]),
		.ex3Flush(ex3Flush), .valPc(valPc), .valGbr(valGbr), .valLr(valLr),
		.immA(immA), .immB(immB), .inDlr(inDlr), .inDhr(inDhr), .inSp(inSp),
		.valRs(valRs), .valRt(valRt), .valRu(valRu), .valRv(valRv),
		.outDlr(outDlr), .outDhr(outDhr), .outSp(outSp)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout");
		end
	end

	function automatic regGprPkg::regValT wideRandom();
		wideRandom = {$random(seed), $random(seed)};
	endfunction

	// Mostly GPRs, with a few hot registers to force collisions
	function automatic regGprPkg::regIdT destinationId();
		int pick;
		pick = {$random(seed)} % 8;
		if (pick < 4)
			destinationId = 6'({$random(seed)} % 32);
		else if (pick == 4)
			destinationId = 6'({$random(seed)} % 4);
		else if (pick == 5)
			destinationId = destSpecials[{$random(seed)} % 5];
		else if (pick == 6)
			destinationId = `GR_ZZR;
		else
			destinationId = fwdId[{$random(seed)} % 6];
	endfunction

	function automatic regGprPkg::regIdT sourceId();
		int pick;
		pick = {$random(seed)} % 4;
		if (pick < 2)
			sourceId = 6'({$random(seed)} % 32);
		else if (pick == 2)
			sourceId = srcSpecials[{$random(seed)} % 10];
		else
			sourceId = fwdId[{$random(seed)} % 6];	// Hits a forward path
	endfunction

	task automatic driveStimulus();
		regGprPkg::regValT raw;
		for (int i = 0; i < 6; i++)
		begin
			fwdId[i] = destinationId();
			fwdVal[i] = wideRandom();
		end
		idRs = sourceId();
		idRt = sourceId();
		idRu = sourceId();
		idRv = sourceId();
		hold = ({$random(seed)} % 8) == 0;
		ex3Flush = ({$random(seed)} % 8) == 0;
		raw = wideRandom();
		valPc = raw[47:0];
		raw = wideRandom();
		valGbr = raw[47:0];
		raw = wideRandom();
		valLr = raw[47:0];
		raw = wideRandom();
		immA = raw[32:0];
		immB = raw[63:31];
		inDlr = wideRandom();
		inDhr = wideRandom();
		inSp = wideRandom();
	endtask

	function automatic regGprPkg::regValT expectedRead(input regGprPkg::regIdT id,
		input regGprPkg::immValT imm);
		logic signed [32:0] simm;
		regGprPkg::regValT base;
		simm = imm;
		base = '0;	// Unassigned IDs and ZZR
		if (id < `GPR_COUNT)
			base = gprModel[id[4:0]];
		else if (id == `GR_DLR)
			base = dlrModel;
		else if (id == `GR_DHR)
			base = dhrModel;
		else if (id == `GR_SP)
			base = spModel;
		else if (id == `GR_PC)
			base = 64'(valPc);
		else if (id == `GR_GBR)
			base = 64'(valGbr);
		else if (id == `GR_LR)
			base = 64'(valLr);
		else if (id == `GR_IMM)
			base = 64'(simm);
		if (id == `GR_IMM || id == `GR_ZZR)
			return base;
		// Newest stage first, lane A before lane B
		for (int i = 0; i < 6; i++)
			if (fwdId[i] == id)
				return fwdVal[i];
		return base;
	endfunction

	function automatic regGprPkg::regValT nextSpecial(input regGprPkg::regIdT id,
		input regGprPkg::regValT ext);
		if (!ex3Flush && fwdId[4] == id)
			return fwdVal[4];
		if (!ex3Flush && fwdId[5] == id)
			return fwdVal[5];
		return ext;
	endfunction

	task automatic updateModel();
		if (!hold)
		begin
			if (!ex3Flush && fwdId[4] < `GPR_COUNT)
				gprModel[fwdId[4][4:0]] = fwdVal[4];
			if (!ex3Flush && fwdId[5] < `GPR_COUNT)
				gprModel[fwdId[5][4:0]] = fwdVal[5];	// Lane B overwrites lane A
			dlrModel = nextSpecial(`GR_DLR, inDlr);
			dhrModel = nextSpecial(`GR_DHR, inDhr);
			spModel = nextSpecial(`GR_SP, inSp);
		end
	endtask

	task automatic compareValue(input string portName, input regGprPkg::regValT actual,
		input regGprPkg::regValT expected);
		assert (actual === expected)
		else
		begin
			$display("** Error at %0t ns: %s expected %h, actual %h",
				$time, portName, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", portName);
		end
	endtask

	// Check 10 ns before the edge, then step the model across it
	task automatic finishCycle();
		#28;
		compareValue("valRs", valRs, expectedRead(idRs, immA));
		compareValue("valRt", valRt, expectedRead(idRt, immA));
		compareValue("valRu", valRu, expectedRead(idRu, immB));
		compareValue("valRv", valRv, expectedRead(idRv, immB));
		compareValue("outDlr", outDlr, dlrModel);
		compareValue("outDhr", outDhr, dhrModel);
		compareValue("outSp", outSp, spModel);
		@(posedge clock);
		updateModel();
		#2;
	endtask

	initial
	begin
		seed = 32'h67f9_cad9;
		reset = 1'b1;
		hold = 1'b0;
		ex3Flush = 1'b0;
		for (int i = 0; i < 6; i++)
		begin
			fwdId[i] = `GR_ZZR;
			fwdVal[i] = '0;
		end
		idRs = `GR_ZZR;
		idRt = `GR_ZZR;
		idRu = `GR_ZZR;
		idRv = `GR_ZZR;
		valPc = '0;
		valGbr = '0;
		valLr = '0;
		immA = '0;
		immB = '0;
		inDlr = '0;
		inDhr = '0;
		inSp = '0;
		for (int i = 0; i < `GPR_COUNT; i++)
			gprModel[i] = '0;
		dlrModel = '0;
		dhrModel = '0;
		spModel = '0;
		repeat (2) @(posedge clock);
		#2 reset = 1'b0;
		// Sweep all GPRs after reset, four per cycle
		for (int r = 0; r < `GPR_COUNT; r += 4)
		begin
			idRs = 6'(r);
			idRt = 6'(r + 1);
			idRu = 6'(r + 2);
			idRv = 6'(r + 3);
			finishCycle();
		end
		repeat (RANDOM_CYCLES)
		begin
			driveStimulus();
			finishCycle();
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== regGpr4R2W.f ====
+incdir+.
regGprPkg.sv
gprBankLvt.sv
sprReg.sv
gprReadPort.sv
regGpr4R2W.sv
regGpr_assertions.sv
tbRegGpr.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tbRegGpr
FILELIST  = regGpr4R2W.f
BUILD_DIR = obj_dir
PASS_TEXT = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
